//--- hw/rv_pipe_pkg.sv
// rv32i pipeline slice definitions
package rv_pipe_pkg;

    localparam int unsigned XLEN       = 32;              // data path width
    localparam int unsigned REG_ADDR_W = 5;               // register index width
    localparam int unsigned NUM_REGS   = 2 ** REG_ADDR_W; // x0..x31

    // major opcodes, bits [6:0]
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_PASS_B                                        // lui passes the immediate
    } alu_op_e;

    typedef enum logic [1:0] {
        RES_ALU = 2'd0,                                   // alu result
        RES_PC4 = 2'd1                                    // link address for jumps
    } res_src_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_JAL, BR_JALR
    } br_kind_e;

    // instruction format views, msb first
    typedef struct packed {
        logic [6:0] funct7; logic [4:0] rs2; logic [4:0] rs1;
        logic [2:0] funct3; logic [4:0] rd;  logic [6:0] opcode;
    } r_fmt_t;
    typedef struct packed {
        logic [11:0] imm; logic [4:0] rs1; logic [2:0] funct3;
        logic [4:0]  rd;  logic [6:0] opcode;
    } i_fmt_t;
    typedef struct packed {
        logic imm12; logic [5:0] imm10_5; logic [4:0] rs2; logic [4:0] rs1;
        logic [2:0] funct3; logic [3:0] imm4_1; logic imm11; logic [6:0] opcode;
    } b_fmt_t;
    typedef struct packed {
        logic [19:0] imm31_12; logic [4:0] rd; logic [6:0] opcode;
    } u_fmt_t;
    typedef struct packed {
        logic imm20; logic [9:0] imm10_1; logic imm11; logic [7:0] imm19_12;
        logic [4:0] rd; logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r; i_fmt_t i; b_fmt_t b; u_fmt_t u; j_fmt_t j;
    } rv_instr_u;

    typedef struct packed {
        logic     reg_w;                                  // write rd at writeback
        res_src_e res_src;                                // writeback source
        alu_op_e  alu_op;                                 // alu operation
        logic     alu_src;                                // 1 selects imm as operand b
        br_kind_e br_kind;                                // branch / jump kind
    } ctrl_t;                                             // all zero is a bubble

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [XLEN-1:0]       rd1;                       // rs1 value from regfile
        logic [XLEN-1:0]       rd2;                       // rs2 value from regfile
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       imm;                       // sign extended immediate
        logic [XLEN-1:0]       pc_plus4;
    } de_bus_t;

    typedef struct packed {
        logic                  reg_w;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_t;

endpackage

//--- hw/rv_decoder.sv
// rv32i instruction decoder
`timescale 1ns/1ps

module rv_decoder (
    input  rv_pipe_pkg::rv_instr_u       instr_i, // fetched word
    input  logic [rv_pipe_pkg::XLEN-1:0] pc_i,    // its pc
    input  logic                         valid_i, // fetch slot holds an instruction
    output rv_pipe_pkg::de_bus_t         dec_o    // rd1 / rd2 filled by regfile
);
    import rv_pipe_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic            legal;   // encoding is in the supported subset
    ctrl_t           ctrl;
    logic [XLEN-1:0] imm;

    // alu op shared by OP and OP-IMM, alt picks sub / sra
    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode = instr_i.r.opcode;
    assign funct3 = instr_i.r.funct3;
    assign funct7 = instr_i.r.funct7;

    always_comb begin
        ctrl  = '0;
        imm   = '0;
        legal = 1'b1;
        case (opcode)
            OPC_OP: begin
                ctrl.reg_w  = 1'b1;
                ctrl.alu_op = alu_sel(funct3, funct7[5]);
                legal       = (funct7 == 7'b0000000) ||
                              (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            OPC_OP_IMM: begin
                ctrl.reg_w   = 1'b1;
                ctrl.alu_src = 1'b1;
                ctrl.alu_op  = alu_sel(funct3, funct3 == 3'b101 && funct7[5]); // addi never subs
                imm          = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
                if (funct3 == 3'b001) begin
                    legal = (funct7 == 7'b0000000);                   // slli
                end else if (funct3 == 3'b101) begin
                    legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000); // srli / srai
                end
            end
            OPC_LUI: begin
                ctrl.reg_w   = 1'b1;
                ctrl.alu_src = 1'b1;
                ctrl.alu_op  = ALU_PASS_B;
                imm          = {instr_i.u.imm31_12, 12'b0};
            end
            OPC_BRANCH: begin
                imm = {{19{instr_i.b.imm12}}, instr_i.b.imm12, instr_i.b.imm11,
                       instr_i.b.imm10_5, instr_i.b.imm4_1, 1'b0};
                case (funct3)
                    3'b000:  ctrl.br_kind = BR_BEQ;
                    3'b001:  ctrl.br_kind = BR_BNE;
                    3'b100:  ctrl.br_kind = BR_BLT;
                    3'b101:  ctrl.br_kind = BR_BGE;
                    default: legal = 1'b0;                           // bltu / bgeu not in set
                endcase
            end
            OPC_JAL: begin
                ctrl.reg_w   = 1'b1;
                ctrl.res_src = RES_PC4;
                ctrl.br_kind = BR_JAL;
                imm          = {{11{instr_i.j.imm20}}, instr_i.j.imm20, instr_i.j.imm19_12,
                                instr_i.j.imm11, instr_i.j.imm10_1, 1'b0};
            end
            OPC_JALR: begin
                ctrl.reg_w   = 1'b1;
                ctrl.res_src = RES_PC4;
                ctrl.alu_src = 1'b1;
                ctrl.br_kind = BR_JALR;
                imm          = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
                legal        = (funct3 == 3'b000);
            end
            default: legal = 1'b0;                                    // loads, stores, csr ...
        endcase
        if (!valid_i || !legal) begin
            ctrl = '0;                                                // bubble
        end
    end

    assign dec_o = '{
        ctrl:     ctrl,
        rd1:      '0,
        rd2:      '0,
        rs1:      instr_i.r.rs1,
        rs2:      instr_i.r.rs2,
        rd:       instr_i.r.rd,
        pc:       pc_i,
        imm:      imm,
        pc_plus4: pc_i + XLEN'(4)
    };

endmodule

//--- hw/rv_regfile.sv
// integer register file
`timescale 1ns/1ps

module rv_regfile (
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    input  logic [rv_pipe_pkg::REG_ADDR_W-1:0] rs1_i,   // read address a
    input  logic [rv_pipe_pkg::REG_ADDR_W-1:0] rs2_i,   // read address b
    input  rv_pipe_pkg::wb_t                   wb_i,    // write port from execute
    output logic [rv_pipe_pkg::XLEN-1:0]       rd1_o,
    output logic [rv_pipe_pkg::XLEN-1:0]       rd2_o
);
    import rv_pipe_pkg::*;

    logic [XLEN-1:0] regs [1:NUM_REGS-1]; // x0 is not stored
    logic            wr_en;

    assign wr_en = wb_i.reg_w && (wb_i.rd != '0); // x0 writes are dropped

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // x0 reads zero, a same-cycle write is passed straight through
    assign rd1_o = (rs1_i == '0)                  ? '0        :
                   (wr_en && wb_i.rd == rs1_i)    ? wb_i.data :
                                                    regs[rs1_i];
    assign rd2_o = (rs2_i == '0)                  ? '0        :
                   (wr_en && wb_i.rd == rs2_i)    ? wb_i.data :
                                                    regs[rs2_i];

endmodule

//--- hw/rv_reg_d_to_e.sv
// decode to execute pipeline register
`timescale 1ns/1ps

module rv_reg_d_to_e (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 flush_i,  // taken redirect kills the decoded slot
    input  rv_pipe_pkg::de_bus_t d_i,      // decode stage record
    output rv_pipe_pkg::de_bus_t e_o       // execute stage record
);
    import rv_pipe_pkg::*;

    de_bus_t stage_q;

    // the whole record is cleared, a bubble also carries zero rs / rd fields
    // so execute never sees a stale forwarding match
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            stage_q <= '0;       // ctrl zero, nothing writes or branches
        end else if (flush_i) begin
            stage_q <= '0;       // wrong-path instruction becomes a bubble
        end else begin
            stage_q <= d_i;      // normal advance, no stall path
        end
    end

    assign e_o = stage_q;

endmodule

//--- hw/rv_execute.sv
// execute stage with alu, branch resolve and writeback register
`timescale 1ns/1ps

module rv_execute (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  rv_pipe_pkg::de_bus_t         e_i,        // record from d-to-e register
    output rv_pipe_pkg::wb_t             wb_o,       // registered writeback
    output logic                         redirect_o, // taken branch or jump
    output logic [rv_pipe_pkg::XLEN-1:0] target_o    // redirect address
);
    import rv_pipe_pkg::*;

    logic [XLEN-1:0]       op_a;       // forwarded rs1
    logic [XLEN-1:0]       op_b_reg;   // forwarded rs2
    logic [XLEN-1:0]       op_b;       // alu operand b after imm select
    logic [4:0]            shamt;
    logic [XLEN-1:0]       alu_res;
    logic [XLEN-1:0]       result;     // value headed for rd
    logic                  eq;
    logic                  lt;         // signed compare
    logic                  taken;
    logic [XLEN-1:0]       jalr_sum;
    logic                  wb_reg_w_q;
    logic [REG_ADDR_W-1:0] wb_rd_q;
    logic [XLEN-1:0]       wb_data_q;

    // take the value from the writeback stage on a live match
    function automatic logic [XLEN-1:0] fwd_sel(input logic [REG_ADDR_W-1:0] rs,
                                                input logic [XLEN-1:0]       reg_val,
                                                input wb_t                   wb);
        logic hit;
        hit = wb.reg_w && (wb.rd != '0) && (wb.rd == rs);
        return hit ? wb.data : reg_val;
    endfunction

    assign op_a     = fwd_sel(e_i.rs1, e_i.rd1, wb_o);
    assign op_b_reg = fwd_sel(e_i.rs2, e_i.rd2, wb_o);
    assign op_b     = e_i.ctrl.alu_src ? e_i.imm : op_b_reg;
    assign shamt    = op_b[4:0];                            // only low 5 bits shift

    always_comb begin
        case (e_i.ctrl.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SLT:    alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_SLL:    alu_res = op_a << shamt;
            ALU_SRL:    alu_res = op_a >> shamt;
            ALU_SRA:    alu_res = $unsigned($signed(op_a) >>> shamt);
            ALU_PASS_B: alu_res = op_b;                      // lui
            default:    alu_res = '0;
        endcase
    end

    // branch compare always uses the register operands
    assign eq = (op_a == op_b_reg);
    assign lt = ($signed(op_a) < $signed(op_b_reg));

    always_comb begin
        case (e_i.ctrl.br_kind)
            BR_BEQ:  taken = eq;
            BR_BNE:  taken = !eq;
            BR_BLT:  taken = lt;
            BR_BGE:  taken = !lt;
            BR_JAL:  taken = 1'b1;
            BR_JALR: taken = 1'b1;
            default: taken = 1'b0;                           // bubble or plain alu op
        endcase
    end

    assign jalr_sum   = op_a + e_i.imm;
    assign redirect_o = taken;
    assign target_o   = (e_i.ctrl.br_kind == BR_JALR) ? {jalr_sum[XLEN-1:1], 1'b0}
                                                       : e_i.pc + e_i.imm;

    assign result = (e_i.ctrl.res_src == RES_PC4) ? e_i.pc_plus4 : alu_res; // link for jumps

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_reg_w_q <= 1'b0;
        end else begin
            wb_reg_w_q <= e_i.ctrl.reg_w;
        end
    end

    always_ff @(posedge clk_i) begin
        wb_rd_q   <= e_i.rd;                                 // payload, qualified by reg_w
        wb_data_q <= result;
    end

    assign wb_o = '{reg_w: wb_reg_w_q, rd: wb_rd_q, data: wb_data_q};

endmodule

//--- hw/rv_de_slice_top.sv
// decode to execute slice top level
`timescale 1ns/1ps

module rv_de_slice_top (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic [rv_pipe_pkg::XLEN-1:0] instr_i,       // fetched word
    input  logic [rv_pipe_pkg::XLEN-1:0] pc_i,          // pc of instr_i
    input  logic                         instr_valid_i, // fetch slot valid
    output rv_pipe_pkg::wb_t             wb_o,          // retired result
    output logic                         pc_src_o,      // redirect fetch
    output logic [rv_pipe_pkg::XLEN-1:0] pc_target_o    // redirect address
);
    import rv_pipe_pkg::*;

    rv_instr_u       instr_w;   // same word, format views
    de_bus_t         dec_w;     // decoder record without operands
    de_bus_t         de_d_w;    // full decode-stage record
    de_bus_t         de_e_w;    // execute-stage record
    logic [XLEN-1:0] rd1_w;
    logic [XLEN-1:0] rd2_w;

    assign instr_w = instr_i;

    rv_decoder u_decoder (
        .instr_i (instr_w),
        .pc_i    (pc_i),
        .valid_i (instr_valid_i),
        .dec_o   (dec_w)
    );

    rv_regfile u_regfile (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .rs1_i   (dec_w.rs1),
        .rs2_i   (dec_w.rs2),
        .wb_i    (wb_o),          // write port fed back from execute
        .rd1_o   (rd1_w),
        .rd2_o   (rd2_w)
    );

    // operands from the regfile join the decoded fields
    assign de_d_w = '{
        ctrl:     dec_w.ctrl,
        rd1:      rd1_w,
        rd2:      rd2_w,
        rs1:      dec_w.rs1,
        rs2:      dec_w.rs2,
        rd:       dec_w.rd,
        pc:       dec_w.pc,
        imm:      dec_w.imm,
        pc_plus4: dec_w.pc_plus4
    };

    rv_reg_d_to_e u_reg_d_to_e (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (pc_src_o),      // kill the slot decoded behind a taken branch
        .d_i     (de_d_w),
        .e_o     (de_e_w)
    );

    rv_execute u_execute (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .e_i        (de_e_w),
        .wb_o       (wb_o),
        .redirect_o (pc_src_o),
        .target_o   (pc_target_o)
    );

endmodule

//--- testbench/tb_clock_gen.sv
// testbench clock and reset
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,    // 8 ns period
    output logic rst_n_o   // active low
);
    localparam int HALF_PERIOD_NS = 4;
    localparam int RESET_CYCLES   = 3;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;   // released on the third rising edge
    end

endmodule

//--- testbench/tb_rv_de_slice.sv
// decode to execute slice testbench
`timescale 1ns/1ps

module tb_rv_de_slice;
    import rv_pipe_pkg::*;

    localparam int    NUM_VEC        = 25;                  // lines in the stimulus file
    localparam int    FIELDS         = 8;                   // words per line
    localparam int    TIMEOUT_CYCLES = 4 * NUM_VEC + 20;
    localparam string STIM_FILE      = "testbench/rv_de_slice_stim.txt";

    // word offsets inside one vector
    localparam int F_INSTR    = 0;
    localparam int F_PC       = 1;
    localparam int F_VALID    = 2;
    localparam int F_REG_W    = 3;
    localparam int F_RD       = 4;
    localparam int F_DATA     = 5;
    localparam int F_REDIRECT = 6;
    localparam int F_TARGET   = 7;

    logic            clk;
    logic            rst_n;
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] pc;
    logic            instr_valid;
    wb_t             wb_obs;                                // writeback seen at the top
    logic            pc_src;
    logic [XLEN-1:0] pc_target;
    logic [31:0]     stim_mem [0:NUM_VEC*FIELDS-1];         // flat vector store
    int              cycle_count = 0;
    int              fd;

    tb_clock_gen u_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    rv_de_slice_top uut (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .instr_i       (instr),
        .pc_i          (pc),
        .instr_valid_i (instr_valid),
        .wb_o          (wb_obs),
        .pc_src_o      (pc_src),
        .pc_target_o   (pc_target)
    );

    // compares an observed value with its expected value
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s = 0x%08h, expected 0x%08h", name, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // one fetch slot per edge with idle slots past the end of the file
    task automatic drive_vector(input int vec);
        int b;
        b = vec * FIELDS;
        if (vec < NUM_VEC) begin
            instr       <= stim_mem[b+F_INSTR];
            pc          <= stim_mem[b+F_PC];
            instr_valid <= stim_mem[b+F_VALID][0];
        end else begin
            instr       <= '0;
            pc          <= '0;
            instr_valid <= 1'b0;                            // drains the pipe
        end
    endtask

    // branch outcome of a slot is visible one edge after it was driven
    task automatic check_redirect(input int vec);
        int b;
        b = vec * FIELDS;
        check_value($sformatf("pc_src_o[slot %0d]", vec), 32'(pc_src),
                    stim_mem[b+F_REDIRECT]);
        if (stim_mem[b+F_REDIRECT][0]) begin
            check_value($sformatf("pc_target_o[slot %0d]", vec), pc_target,
                        stim_mem[b+F_TARGET]);
        end
    endtask

    // writeback of a slot appears two edges after it was driven
    task automatic check_writeback(input int vec);
        int b;
        b = vec * FIELDS;
        check_value($sformatf("wb_o.reg_w[slot %0d]", vec), 32'(wb_obs.reg_w),
                    stim_mem[b+F_REG_W]);
        if (stim_mem[b+F_REG_W][0]) begin                   // rd and data matter only with reg_w
            check_value($sformatf("wb_o.rd[slot %0d]", vec), 32'(wb_obs.rd),
                        stim_mem[b+F_RD]);
            check_value($sformatf("wb_o.data[slot %0d]", vec), wb_obs.data,
                        stim_mem[b+F_DATA]);
        end
    endtask

    // watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("RESULT: FAIL");
            $fatal(1, "watchdog expired");
        end
    end

    initial begin
        instr       = '0;
        pc          = '0;
        instr_valid = 1'b0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("could not open the stimulus file %s", STIM_FILE);
            $display("RESULT: FAIL");
            $fatal(1, "stimulus file missing");
        end
        $fclose(fd);
        $readmemh(STIM_FILE, stim_mem);
        @(posedge rst_n);
        @(negedge clk);
        // nothing retires or redirects straight out of reset
        check_value("wb_o.reg_w after reset", 32'(wb_obs.reg_w), 32'h0);
        check_value("pc_src_o after reset", 32'(pc_src), 32'h0);
        for (int k = 0; k < NUM_VEC + 2; k++) begin
            @(posedge clk);
            drive_vector(k);
            @(negedge clk);                                 // outputs settled mid cycle
            if (k >= 1 && k <= NUM_VEC) begin
                check_redirect(k - 1);
            end
            if (k >= 2) begin
                check_writeback(k - 2);
            end
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- testbench/rv_de_slice_stim.txt
// instr pc valid | expected wb reg_w, rd, data | expected redirect, target (all hex)
// one fetch slot per line, fields not qualified by reg_w or redirect are zero
00500093 000000fc 0 0 00 00000000 0 00000000
00500093 00000100 1 1 01 00000005 0 00000000
ffd00113 00000104 1 1 02 fffffffd 0 00000000
002081b3 00000108 1 1 03 00000002 0 00000000
40208233 0000010c 1 1 04 00000008 0 00000000
001122b3 00000110 1 1 05 00000001 0 00000000
00113333 00000114 1 1 06 00000000 0 00000000
401153b3 00000118 1 1 07 ffffffff 0 00000000
00115433 0000011c 1 1 08 07ffffff 0 00000000
0f014493 00000120 1 1 09 ffffff0d 0 00000000
12345537 00000124 1 1 0a 12345000 0 00000000
00451593 00000128 1 1 0b 23450000 0 00000000
00708013 0000012c 1 1 00 0000000c 0 00000000
00100633 00000130 1 1 0c 00000005 0 00000000
00c08863 00000134 1 0 00 00000000 1 00000144
00100693 00000138 1 0 00 00000000 0 00000000
00c09463 00000144 1 0 00 00000000 0 00000000
fe114ce3 00000148 1 0 00 00000000 1 00000140
0200076f 0000014c 1 0 00 00000000 0 00000000
00115663 00000140 1 0 00 00000000 0 00000000
040007ef 00000144 1 1 0f 00000148 1 00000184
00108833 00000148 1 0 00 00000000 0 00000000
003788e7 00000184 1 1 11 00000188 1 0000014a
00900913 00000188 1 0 00 00000000 0 00000000
00002983 0000014a 1 0 00 00000000 0 00000000

//--- files.f
hw/rv_pipe_pkg.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_reg_d_to_e.sv
hw/rv_execute.sv
hw/rv_de_slice_top.sv
testbench/tb_clock_gen.sv
testbench/tb_rv_de_slice.sv

//--- run_sim.sh
#!/bin/sh
# build the slice testbench with verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_rv_de_slice -f files.f -o sim_tb \
    && ./obj_dir/sim_tb \
    || { echo "simulation did not complete cleanly" >&2; exit 1; }

exit 0
